/* rtl/fv_info_pkg.sv */
// Shared widths, bus structs and controller states for the feature-vector info lookup stage
`default_nettype none

package fv_info_pkg;

    // Table of 128 nodes, 4 edge PEs
    localparam int node_id_w = 7;
    localparam int pe_tag_w  = 2;
    // Feature-vector address, also the table word
    localparam int fv_addr_w = 10;

    // One queued lookup request from an edge PE
    typedef struct packed {
        logic [node_id_w-1:0] node_id;
        logic [pe_tag_w-1:0]  pe_tag;
    } fv_req_t;

    // One lookup result for the feature-vector FIFO
    typedef struct packed {
        logic [fv_addr_w-1:0] fv_addr;
        logic [pe_tag_w-1:0]  pe_tag;
    } fv_resp_t;

    // Access to the table, en doubles as the arbiter request
    typedef struct packed {
        logic                 en;
        logic                 we;
        logic [node_id_w-1:0] addr;
        logic [fv_addr_w-1:0] wdata;
    } sram_req_t;

    typedef enum logic [1:0] {
        idle,
        request,
        data,
        hold
    } cntl_state_t;

endpackage

`default_nettype wire

/* rtl/fv_info_req_fifo.sv */
// Synchronous FIFO that queues PE lookup requests in arrival order for the memory controller
`timescale 1ns/1ps
`default_nettype none

module fv_info_req_fifo #(
    parameter int fifo_depth = 16
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  fv_info_pkg::fv_req_t wdata,
    input  logic                pop,
    output fv_info_pkg::fv_req_t rdata,
    output logic                empty
);

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);

    fv_info_pkg::fv_req_t mem [fifo_depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_pop;

    // Wraps at the depth, which need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        if (p == ptr_w'(fifo_depth - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign empty  = (count == '0);
    assign do_pop = pop && !empty;
    assign rdata  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/fv_info_mem_cntl.sv */
// Lookup controller: pops a request, reads the node table and hands the result downstream
`timescale 1ns/1ps
`default_nettype none

module fv_info_mem_cntl (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 fifo_empty,
    input  fv_info_pkg::fv_req_t                 fifo_head,
    output logic                                 fifo_pop,
    output fv_info_pkg::sram_req_t               sram_req,
    input  logic                                 sram_gnt,
    input  logic [fv_info_pkg::fv_addr_w-1:0]    sram_rdata,
    input  logic                                 fv_fifo_full,
    output logic                                 out_valid,
    output fv_info_pkg::fv_resp_t                out
);

    fv_info_pkg::cntl_state_t state;

    logic [fv_info_pkg::pe_tag_w-1:0] tag_q;
    logic                             granted;

    assign granted = (state == fv_info_pkg::request) && sram_gnt;

    // Read only, address taken straight from the FIFO head
    assign sram_req.en    = (state == fv_info_pkg::request);
    assign sram_req.we    = 1'b0;
    assign sram_req.addr  = fifo_head.node_id;
    assign sram_req.wdata = '0;

    // Head leaves the FIFO once the table read is underway
    assign fifo_pop  = granted;
    assign out_valid = (state == fv_info_pkg::hold);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fv_info_pkg::idle;
        end else begin
            case (state)
                fv_info_pkg::idle: begin
                    if (!fifo_empty) begin
                        state <= fv_info_pkg::request;
                    end
                end
                fv_info_pkg::request: begin
                    if (sram_gnt) begin
                        state <= fv_info_pkg::data;
                    end
                end
                fv_info_pkg::data: begin
                    state <= fv_info_pkg::hold;
                end
                fv_info_pkg::hold: begin
                    // Stay put while downstream is full
                    if (!fv_fifo_full) begin
                        state <= fv_info_pkg::idle;
                    end
                end
                default: begin
                    state <= fv_info_pkg::idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (granted) begin
            tag_q <= fifo_head.pe_tag;
        end
        // SRAM word arrives the cycle after the grant
        if (state == fv_info_pkg::data) begin
            out.fv_addr <= sram_rdata;
            out.pe_tag  <= tag_q;
        end
    end

endmodule

`default_nettype wire

/* rtl/fv_info_wb_loader.sv */
// Wishbone classic slave for host writes and read-back of the node table via the arbiter
`timescale 1ns/1ps
`default_nettype none

module fv_info_wb_loader (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              wb_cyc,
    input  logic                              wb_stb,
    input  logic                              wb_we,
    input  logic [fv_info_pkg::node_id_w-1:0] wb_adr,
    input  logic [fv_info_pkg::fv_addr_w-1:0] wb_dat_w,
    output logic [fv_info_pkg::fv_addr_w-1:0] wb_dat_r,
    output logic                              wb_ack,
    output fv_info_pkg::sram_req_t            sram_req,
    input  logic                              sram_gnt,
    input  logic [fv_info_pkg::fv_addr_w-1:0] sram_rdata
);

    logic active;
    logic served;
    logic ack_q;

    assign active = wb_cyc && wb_stb;

    // One table access per strobe
    assign sram_req.en    = active && !served;
    assign sram_req.we    = wb_we;
    assign sram_req.addr  = wb_adr;
    assign sram_req.wdata = wb_dat_w;

    assign wb_ack = ack_q;
    // Read word lands together with the ack
    assign wb_dat_r = sram_rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            served <= 1'b0;
            ack_q  <= 1'b0;
        end else begin
            ack_q <= sram_req.en && sram_gnt;
            if (sram_req.en && sram_gnt) begin
                served <= 1'b1;
            end else if (!active) begin
                served <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/fv_info_sram_arbiter.sv */
// Two-way round-robin arbiter sharing the table port between the controller and the loader
`timescale 1ns/1ps
`default_nettype none

module fv_info_sram_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  fv_info_pkg::sram_req_t req_a,
    input  fv_info_pkg::sram_req_t req_b,
    output logic                   gnt_a,
    output logic                   gnt_b,
    output fv_info_pkg::sram_req_t mem_req
);

    // High when the loader won the most recent grant
    logic last_b;

    assign gnt_a = req_a.en && (!req_b.en || last_b);
    assign gnt_b = req_b.en && (!req_a.en || !last_b);

    // With no grant, req_a carries en low
    always_comb begin
        mem_req = req_a;
        if (gnt_b) begin
            mem_req = req_b;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // Controller goes first on the first conflict
            last_b <= 1'b1;
        end else if (gnt_a) begin
            last_b <= 1'b0;
        end else if (gnt_b) begin
            last_b <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/fv_info_sram.sv */
// Single-port node table mapping node id to feature-vector address, one-cycle read latency
`timescale 1ns/1ps
`default_nettype none

module fv_info_sram (
    input  logic                              clk,
    input  fv_info_pkg::sram_req_t            mem_req,
    output logic [fv_info_pkg::fv_addr_w-1:0] rdata
);

    logic [fv_info_pkg::fv_addr_w-1:0] table_mem [2**fv_info_pkg::node_id_w];

    always_ff @(posedge clk) begin
        if (mem_req.en) begin
            if (mem_req.we) begin
                table_mem[mem_req.addr] <= mem_req.wdata;
            end else begin
                rdata <= table_mem[mem_req.addr];
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/fv_info_integration.sv */
// Top of the feature-vector info lookup stage, instantiated by the testbench as the DUT
`timescale 1ns/1ps
`default_nettype none

module fv_info_integration #(
    parameter int fifo_depth = 16
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              req_valid,
    input  fv_info_pkg::fv_req_t              req,
    input  logic                              fv_fifo_full,
    output logic                              out_valid,
    output fv_info_pkg::fv_resp_t             out,
    input  logic                              wb_cyc,
    input  logic                              wb_stb,
    input  logic                              wb_we,
    input  logic [fv_info_pkg::node_id_w-1:0] wb_adr,
    input  logic [fv_info_pkg::fv_addr_w-1:0] wb_dat_w,
    output logic [fv_info_pkg::fv_addr_w-1:0] wb_dat_r,
    output logic                              wb_ack
);

    fv_info_pkg::fv_req_t   fifo_head;
    logic                   fifo_empty;
    logic                   fifo_pop;

    fv_info_pkg::sram_req_t cntl_req;
    fv_info_pkg::sram_req_t load_req;
    fv_info_pkg::sram_req_t mem_req;
    logic                   cntl_gnt;
    logic                   load_gnt;

    logic [fv_info_pkg::fv_addr_w-1:0] sram_rdata;

    // Sized for every outstanding PE request, so no full flag
    fv_info_req_fifo #(
        .fifo_depth (fifo_depth)
    ) u_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (req_valid),
        .wdata (req),
        .pop   (fifo_pop),
        .rdata (fifo_head),
        .empty (fifo_empty)
    );

    fv_info_mem_cntl u_cntl (
        .clk          (clk),
        .rst          (rst),
        .fifo_empty   (fifo_empty),
        .fifo_head    (fifo_head),
        .fifo_pop     (fifo_pop),
        .sram_req     (cntl_req),
        .sram_gnt     (cntl_gnt),
        .sram_rdata   (sram_rdata),
        .fv_fifo_full (fv_fifo_full),
        .out_valid    (out_valid),
        .out          (out)
    );

    fv_info_wb_loader u_loader (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .sram_req   (load_req),
        .sram_gnt   (load_gnt),
        .sram_rdata (sram_rdata)
    );

    fv_info_sram_arbiter u_arbiter (
        .clk     (clk),
        .rst     (rst),
        .req_a   (cntl_req),
        .req_b   (load_req),
        .gnt_a   (cntl_gnt),
        .gnt_b   (load_gnt),
        .mem_req (mem_req)
    );

    fv_info_sram u_sram (
        .clk     (clk),
        .mem_req (mem_req),
        .rdata   (sram_rdata)
    );

endmodule

`default_nettype wire

/* bench/fv_info_props.sv */
// Arbiter assertions, bound into the SRAM arbiter from the testbench
`timescale 1ns/1ps
`default_nettype none

module fv_info_props (
    input logic                   clk,
    input logic                   rst,
    input fv_info_pkg::sram_req_t req_a,
    input fv_info_pkg::sram_req_t req_b,
    input logic                   gnt_a,
    input logic                   gnt_b,
    input fv_info_pkg::sram_req_t mem_req
);

    one_grant: assert property (@(posedge clk) disable iff (rst) !(gnt_a && gnt_b))
        else $error("Arbiter granted both peers in one cycle");

    // The granted request is the one that reaches the table
    gnt_a_with_req: assert property (@(posedge clk) disable iff (rst)
        gnt_a |-> req_a.en && (mem_req == req_a))
        else $error("Controller granted without its request on the table port");

    gnt_b_with_req: assert property (@(posedge clk) disable iff (rst)
        gnt_b |-> req_b.en && (mem_req == req_b))
        else $error("Loader granted without its request on the table port");

    // A waiting peer keeps asking
    req_a_held: assert property (@(posedge clk) disable iff (rst)
        (req_a.en && !gnt_a) |=> req_a.en)
        else $error("Controller request dropped before its grant");

    req_b_held: assert property (@(posedge clk) disable iff (rst)
        (req_b.en && !gnt_b) |=> req_b.en)
        else $error("Loader request dropped before its grant");

endmodule

`default_nettype wire

/* bench/fv_info_checker.sv */
// Scoreboard for the lookup stage: mirrors table writes, checks lookups, read-back and acks
`timescale 1ns/1ps
`default_nettype none

module fv_info_checker (
    input logic                              clk,
    input logic                              rst,
    input logic                              req_valid,
    input fv_info_pkg::fv_req_t              req,
    input logic                              fv_fifo_full,
    input logic                              out_valid,
    input fv_info_pkg::fv_resp_t             out,
    input logic                              wb_cyc,
    input logic                              wb_stb,
    input logic                              wb_we,
    input logic [fv_info_pkg::node_id_w-1:0] wb_adr,
    input logic [fv_info_pkg::fv_addr_w-1:0] wb_dat_w,
    input logic [fv_info_pkg::fv_addr_w-1:0] wb_dat_r,
    input logic                              wb_ack
);

    logic [fv_info_pkg::fv_addr_w-1:0] table_model [2**fv_info_pkg::node_id_w];
    logic [fv_info_pkg::fv_addr_w-1:0] rd_q [$];
    fv_info_pkg::fv_resp_t             exp_q [$];
    fv_info_pkg::fv_resp_t             prev_out;

    logic started   = 1'b0;
    logic wb_open   = 1'b0;
    logic wb_acked  = 1'b0;
    logic prev_hold = 1'b0;
    int   err_count  = 0;
    int   req_count  = 0;
    int   xfer_count = 0;
    int   wb_cycles  = 0;

    task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] want);
        $display("Fail at %0t: %s got %0h expected %0h", $time, name, got, want);
        err_count++;
    endtask

    task automatic event_error(input string what);
        $display("Error at %0t: %s", $time, what);
        err_count++;
    endtask

    // Sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        fv_info_pkg::fv_resp_t             want;
        logic [fv_info_pkg::fv_addr_w-1:0] want_rd;
        if (!rst) begin
            if (!started && (out_valid || wb_ack)) begin
                event_error("out_valid or wb_ack went high before any stimulus");
            end
            started = started || wb_cyc || req_valid;
            if (req_valid) begin
                want.fv_addr = table_model[req.node_id];
                want.pe_tag  = req.pe_tag;
                exp_q.push_back(want);
                req_count++;
            end
            if (prev_hold && !out_valid) begin
                event_error("out_valid dropped while fv_fifo_full was high");
            end
            if (prev_hold && out != prev_out) begin
                value_error("out", 32'(out), 32'(prev_out));
            end
            if (out_valid && !fv_fifo_full) begin
                xfer_count++;
                if (exp_q.size() == 0) begin
                    event_error("a result was transferred with no request outstanding");
                end else begin
                    want = exp_q.pop_front();
                    if (out.fv_addr != want.fv_addr) begin
                        value_error("out.fv_addr", 32'(out.fv_addr), 32'(want.fv_addr));
                    end
                    if (out.pe_tag != want.pe_tag) begin
                        value_error("out.pe_tag", 32'(out.pe_tag), 32'(want.pe_tag));
                    end
                end
            end
            prev_hold = out_valid && fv_fifo_full;
            prev_out  = out;
            if (wb_cyc && wb_stb && !wb_open) begin
                wb_open  = 1'b1;
                wb_acked = 1'b0;
                wb_cycles++;
                if (!wb_we) begin
                    rd_q.push_back(table_model[wb_adr]);
                end
            end
            if (wb_ack) begin
                if (!wb_open || wb_acked) begin
                    event_error("wb_ack arrived with no Wishbone cycle waiting for it");
                end else if (wb_we) begin
                    wb_acked = 1'b1;
                    table_model[wb_adr] = wb_dat_w;
                end else begin
                    wb_acked = 1'b1;
                    want_rd = rd_q.pop_front();
                    if (wb_dat_r != want_rd) begin
                        value_error("wb_dat_r", 32'(wb_dat_r), 32'(want_rd));
                    end
                end
            end
            if (wb_open && !(wb_cyc && wb_stb)) begin
                if (!wb_acked) begin
                    event_error("Wishbone strobe ended without an ack");
                end
                wb_open = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* bench/fv_info_tb.sv */
// Testbench top for the lookup stage: xorshift traffic on Wishbone and PE ports with back-pressure
`timescale 1ns/1ps
`default_nettype none

module fv_info_tb;

    localparam int          fifo_depth = 16;
    localparam logic [31:0] seed       = 32'h3236_c0b2;

    logic clk, rst, req_valid, fv_fifo_full, out_valid;
    logic wb_cyc, wb_stb, wb_we, wb_ack;
    logic [fv_info_pkg::node_id_w-1:0] wb_adr;
    logic [fv_info_pkg::fv_addr_w-1:0] wb_dat_w, wb_dat_r;
    fv_info_pkg::fv_req_t              req;
    fv_info_pkg::fv_resp_t             out;

    logic [31:0] rng_wb, rng_pe, rng_bp;
    logic        wb_done, pe_done;
    int          pe_sent, tb_errors;

    fv_info_integration #(.fifo_depth(fifo_depth)) uut (.*);
    fv_info_checker chk (.*);
    bind fv_info_sram_arbiter fv_info_props u_props (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // Master holds the strobe until ack, then leaves one idle cycle
    task automatic wb_cycle(input logic we, input logic [6:0] adr, input logic [9:0] dat);
        int   waited;
        logic got;
        waited = 0;
        got    = 1'b0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= dat;
        while (!got && waited < 50) begin
            @(negedge clk);
            got = wb_ack;
            waited++;
        end
        if (!got) begin
            $display("Wishbone access to address %0d got no ack within 50 cycles", adr);
            tb_errors++;
        end
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_stream(input int n);
        for (int i = 0; i < n; i++) begin
            rng_wb = xorshift(rng_wb);
            repeat (rng_wb[2:0]) @(posedge clk);
            wb_cycle(1'b0, rng_wb[14:8], '0);
        end
        wb_done = 1'b1;
    endtask

    // Never more than fifo_depth lookups outstanding
    task automatic pe_stream(input int n);
        int sent;
        int idle;
        sent = 0;
        idle = 0;
        while (sent < n && idle < 2000) begin
            @(posedge clk);
            rng_pe = xorshift(rng_pe);
            if (rng_pe[1:0] != 2'b00 && (pe_sent - chk.xfer_count) < fifo_depth) begin
                req_valid   <= 1'b1;
                req.node_id <= rng_pe[10:4];
                req.pe_tag  <= rng_pe[13:12];
                pe_sent++;
                sent++;
                idle = 0;
            end else begin
                req_valid <= 1'b0;
                idle++;
            end
        end
        @(posedge clk);
        req_valid <= 1'b0;
        if (sent < n) begin
            $display("PE requests stalled: no room in the request FIFO for 2000 cycles");
            tb_errors++;
        end
        pe_done = 1'b1;
    endtask

    task automatic bp_stream(input logic enable);
        int cycles;
        cycles = 0;
        while (!(wb_done && pe_done) && cycles < 20000) begin
            @(posedge clk);
            rng_bp = xorshift(rng_bp);
            fv_fifo_full <= enable && (rng_bp[1:0] != 2'b00);
            cycles++;
        end
        @(posedge clk);
        fv_fifo_full <= 1'b0;
        if (cycles >= 20000) begin
            $display("Traffic phase did not finish within 20000 cycles");
            tb_errors++;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (chk.xfer_count != pe_sent && waited < 2000) begin
            @(negedge clk);
            waited++;
        end
        if (chk.xfer_count != pe_sent) begin
            $display("Lookups did not drain: %0d sent, %0d transferred", pe_sent, chk.xfer_count);
            tb_errors++;
        end
    endtask

    task automatic run_mix(input int n_wb, input int n_pe, input logic with_bp);
        wb_done = 1'b0;
        pe_done = 1'b0;
        fork
            wb_stream(n_wb);
            pe_stream(n_pe);
            bp_stream(with_bp);
        join
        wait_drain();
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        fv_fifo_full = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        rng_wb       = seed;
        rng_pe       = seed ^ 32'h9e37_79b9;
        rng_bp       = seed ^ 32'h7f4a_7c15;
        wb_done      = 1'b0;
        pe_done      = 1'b0;
        pe_sent      = 0;
        tb_errors    = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        // Quiet window, outputs must stay low
        repeat (4) @(posedge clk);
        for (int a = 0; a < 128; a++) begin
            rng_wb = xorshift(rng_wb);
            wb_cycle(1'b1, 7'(a), rng_wb[9:0]);
        end
        run_mix(40, 60, 1'b0);
        // Table rewritten only while no lookup is in flight
        for (int i = 0; i < 16; i++) begin
            rng_wb = xorshift(rng_wb);
            wb_cycle(1'b1, rng_wb[22:16], rng_wb[9:0]);
        end
        run_mix(40, 80, 1'b1);
        repeat (5) @(posedge clk);
        if (chk.xfer_count != chk.req_count) begin
            $display("Transfers (%0d) do not match requests (%0d)", chk.xfer_count, chk.req_count);
            tb_errors++;
        end
        if (chk.wb_open) begin
            $display("A Wishbone cycle is still open at the end of the run");
            tb_errors++;
        end
        $display("Errors %0d (checker %0d, bench %0d), requests %0d, transfers %0d, wb cycles %0d",
                 chk.err_count + tb_errors, chk.err_count, tb_errors, chk.req_count,
                 chk.xfer_count, chk.wb_cycles);
        if (chk.err_count + tb_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
rtl/fv_info_pkg.sv
rtl/fv_info_req_fifo.sv
rtl/fv_info_mem_cntl.sv
rtl/fv_info_wb_loader.sv
rtl/fv_info_sram_arbiter.sv
rtl/fv_info_sram.sv
rtl/fv_info_integration.sv
bench/fv_info_props.sv
bench/fv_info_checker.sv
bench/fv_info_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the lookup-stage testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")"
log=sim.log

verilator --binary --timing --assert -f tb.f --top-module fv_info_tb -o fv_info_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fv_info_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "RESULT: PASS" "$log"; then
    exit 0
fi
echo "Pass message not found in $log"
exit 1
